//--- src/nocPkg.sv
package nocPkg;

  localparam int NumPorts = 5;

  // Router port order, also the arbitration order
  typedef enum logic [2:0]
  {
    Local = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    West  = 3'd3,
    South = 3'd4
  } portE;

  typedef enum logic [2:0]
  {
    None   = 3'd0,
    Header = 3'd1, // Only kind that loads a tenure length
    Body   = 3'd2,
    Tail   = 3'd3
  } flitKindE;

  // GrantX value is port index plus one
  typedef enum logic [2:0]
  {
    Idle   = 3'd0,
    GrantL = 3'd1,
    GrantN = 3'd2,
    GrantE = 3'd3,
    GrantW = 3'd4,
    GrantS = 3'd5
  } arbStateE;

  typedef struct packed
  {
    flitKindE    flitId;
    logic [11:0] length;  // Tenure limit when flitId is Header
    logic [15:0] payload;
  } flitT;

endpackage

//--- src/grantTimer.sv
`timescale 1ns/1ps

module grantTimer import nocPkg::*;
(
  input  logic clk,
  input  logic rst,
  input  flitT headFlit,
  input  logic runTimer,
  output logic timesUp
);

  logic [11:0] limit;
  logic [11:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (headFlit.flitId == Header)
        limit <= headFlit.length; // Any header seen at the head
      // Held cycles of the current tenure
      if (runTimer)
        count <= count + 12'd1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == limit);

endmodule

//--- src/portArbiter.sv
`timescale 1ns/1ps

module portArbiter import nocPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [NumPorts-1:0] req,
  input  flitT                headFlit [NumPorts],
  output logic [NumPorts-1:0] grant
);

  arbStateE state;
  arbStateE nextState;

  logic [NumPorts-1:0] runTimer;
  logic [NumPorts-1:0] timesUp;

  // First requester among span ports starting at first, wrapping after South
  function automatic arbStateE pickNext(input logic [NumPorts-1:0] reqs,
                                        input portE first,
                                        input int span);
    arbStateE pick;
    portE     cand;
    pick = Idle;
    for (int k = span - 1; k >= 0; k--)
    begin
      cand = portE'((int'(first) + k) % NumPorts);
      if (reqs[cand])
        pick = arbStateE'(int'(cand) + 1); // Lowest k wins
    end
    return pick;
  endfunction

  for (genvar p = 0; p < NumPorts; p++)
  begin : gTimer
    grantTimer iTimer
    (
      .clk      (clk),
      .rst      (rst),
      .headFlit (headFlit[p]),
      .runTimer (runTimer[p]),
      .timesUp  (timesUp[p])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= Idle;
    else
      state <= nextState;
  end

  always_comb
  begin
    grant     = '0;
    runTimer  = '0;
    nextState = Idle;
    case (state)
      Idle:
        nextState = pickNext(req, Local, NumPorts);
      GrantL:
      begin
        if (req[Local] && !timesUp[Local])
        begin
          grant[Local]    = 1'b1;
          runTimer[Local] = 1'b1;
          nextState       = GrantL;
        end
        else
          nextState = pickNext(req, North, NumPorts - 1); // Never back to L
      end
      GrantN:
      begin
        if (req[North] && !timesUp[North])
        begin
          grant[North]    = 1'b1;
          runTimer[North] = 1'b1;
          nextState       = GrantN;
        end
        else
          nextState = pickNext(req, East, NumPorts - 1);
      end
      GrantE:
      begin
        if (req[East] && !timesUp[East])
        begin
          grant[East]    = 1'b1;
          runTimer[East] = 1'b1;
          nextState      = GrantE;
        end
        else
          nextState = pickNext(req, West, NumPorts - 1);
      end
      GrantW:
      begin
        if (req[West] && !timesUp[West])
        begin
          grant[West]    = 1'b1;
          runTimer[West] = 1'b1;
          nextState      = GrantW;
        end
        else
          nextState = pickNext(req, South, NumPorts - 1);
      end
      GrantS:
      begin
        if (req[South] && !timesUp[South])
        begin
          grant[South]    = 1'b1;
          runTimer[South] = 1'b1;
          nextState       = GrantS;
        end
        else
          nextState = pickNext(req, Local, NumPorts - 1); // Wraps to L
      end
      default:
        nextState = Idle;
    endcase
  end

endmodule

//--- src/inputQueue.sv
`timescale 1ns/1ps

module inputQueue import nocPkg::*;
#(
  parameter int QueueDepth = 4
)
(
  input  logic clk,
  input  logic rst,
  input  flitT inFlit,
  input  logic push,
  input  logic pop,
  output flitT headFlit,
  output logic req,
  output logic full
);

  localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int CntW = $clog2(QueueDepth + 1);

  flitT mem [QueueDepth];

  logic [PtrW-1:0] rdPtr;
  logic [PtrW-1:0] wrPtr;
  logic [CntW-1:0] count;
  logic            doWrite;
  logic            doRead;

  assign req  = (count != '0);
  assign full = (count == CntW'(QueueDepth));

  assign doWrite = push && !full; // Overflow flit is lost
  assign doRead  = pop && req;

  assign headFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (doWrite)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= (wrPtr == PtrW'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (doRead)
        rdPtr <= (rdPtr == PtrW'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
      case ({doWrite, doRead})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

endmodule

//--- src/outputStage.sv
`timescale 1ns/1ps

module outputStage import nocPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [NumPorts-1:0] grant,
  input  flitT                headFlit [NumPorts],
  output logic [NumPorts-1:0] pop,
  output flitT                outFlit,
  output logic                outValid
);

  flitT selFlit;

  // Grant only ever goes to a non-empty queue
  assign pop = grant;

  // Grant is one-hot, so a plain priority pick works as the mux
  always_comb
  begin
    selFlit = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (grant[p])
        selFlit = headFlit[p];
    end
  end

  always_ff @(posedge clk)
  begin
    if (|grant)
      outFlit <= selFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |grant; // One strobe per popped flit
  end

endmodule

//--- src/routerOutputPort.sv
`timescale 1ns/1ps

module routerOutputPort import nocPkg::*;
#(
  parameter int QueueDepth = 4
)
(
  input  logic                clk,
  input  logic                rst,
  input  flitT                inFlit [NumPorts],
  input  logic [NumPorts-1:0] inPush,
  output flitT                outFlit,
  output logic                outValid,
  output logic [NumPorts-1:0] full
);

  flitT                headFlit [NumPorts];
  logic [NumPorts-1:0] req;
  logic [NumPorts-1:0] grant;
  logic [NumPorts-1:0] pop;

  // One queue per input link, index order L N E W S
  for (genvar p = 0; p < NumPorts; p++)
  begin : gPort
    inputQueue #(
      .QueueDepth (QueueDepth)
    ) iQueue
    (
      .clk      (clk),
      .rst      (rst),
      .inFlit   (inFlit[p]),
      .push     (inPush[p]),
      .pop      (pop[p]),
      .headFlit (headFlit[p]),
      .req      (req[p]),
      .full     (full[p])
    );
  end

  portArbiter iArbiter
  (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .headFlit (headFlit),
    .grant    (grant)
  );

  outputStage iOutput
  (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .headFlit (headFlit),
    .pop      (pop),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

//--- sim/routerOutputPort_props.sv
`timescale 1ns/1ps

module routerOutputPort_props import nocPkg::*;
(
  input logic                clk,
  input logic                rst,
  input logic [NumPorts-1:0] req,
  input logic [NumPorts-1:0] grant
);

  // Only one port may drive the output link
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant has more than one bit set: %b", grant);

  grantLowAfterReset: assert property (@(posedge clk) rst |=> (grant == '0))
    else $error("grant is not low in the cycle after reset: %b", grant);

  // A held port always has a flit waiting
  grantNeedsReq: assert property (@(posedge clk) disable iff (rst) ((grant & ~req) == '0))
    else $error("grant %b given to a port without request, req %b", grant, req);

endmodule

bind portArbiter routerOutputPort_props iProps
(
  .clk   (clk),
  .rst   (rst),
  .req   (req),
  .grant (grant)
);

//--- sim/routerOutputPort_tb.sv
`timescale 1ns/1ps

module routerOutputPort_tb import nocPkg::*;
();

  localparam int QueueDepth = 4;
  localparam int ClkPeriod  = 4;
  localparam int NumEntries = 5;

  // Burst nibbles and header lengths are packed South first, Local last
  typedef struct packed
  {
    logic [NumPorts-1:0][3:0]  burst;
    logic [NumPorts-1:0][11:0] hdrLen;
    logic [7:0]                gap;
    logic [7:0]                expected;
  } entryT;

  entryT stimTab [NumEntries] = '{
    {20'h0_0004, 60'h000_000_000_000_00f, 8'd6, 8'd4},  // Local alone, long tenure
    {20'h2_2222, 60'h008_008_008_008_008, 8'd6, 8'd10}, // All five at once
    {20'h2_0023, 60'h004_000_000_004_001, 8'd6, 8'd7},  // Short L tenure, rotation
    {20'h0_2410, 60'h000_003_002_005_000, 8'd6, 8'd7},  // East split over two tenures
    {20'h0_1002, 60'h000_000_000_000_003, 8'd10, 8'd2}  // West header of length zero
  };

  logic                clk = 1'b0;
  logic                rst;
  flitT                inFlit [NumPorts];
  logic [NumPorts-1:0] inPush;
  flitT                outFlit;
  logic                outValid;
  logic [NumPorts-1:0] full;

  // Reference model state
  flitT mBuf   [NumPorts][QueueDepth];
  int   mHead  [NumPorts];
  int   mSize  [NumPorts];
  int   mLimit [NumPorts];
  int   mCount [NumPorts];
  int   mOwner = -1;         // -1 while no port holds the grant
  flitT mFlit  = '0;
  logic mValid = 1'b0;

  int seqNum [NumPorts];
  int outCount;

  routerOutputPort #(
    .QueueDepth (QueueDepth)
  ) i_routerOutputPort
  (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inPush   (inPush),
    .outFlit  (outFlit),
    .outValid (outValid),
    .full     (full)
  );

  initial
  begin
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // First requesting port among span ports, starting at start and wrapping
  function automatic int firstRequester(input int start, input int span);
    int pick;
    int cand;
    pick = -1;
    for (int k = 0; k < span; k++)
    begin
      cand = (start + k) % NumPorts;
      if (pick < 0 && mSize[cand] > 0)
        pick = cand;
    end
    return pick;
  endfunction

  always @(posedge clk)
  begin : refModel
    int   held;
    int   nextOwner;
    logic wasFull;
    if (rst)
    begin
      for (int p = 0; p < NumPorts; p++)
      begin
        mHead[p]  = 0;
        mSize[p]  = 0;
        mLimit[p] = 0;
        mCount[p] = 0;
      end
      mOwner = -1;
      mValid = 1'b0;
    end
    else
    begin
      held = -1;
      if (mOwner < 0)
        nextOwner = firstRequester(0, NumPorts);
      else if (mSize[mOwner] > 0 && mCount[mOwner] != mLimit[mOwner])
      begin
        held      = mOwner;
        nextOwner = mOwner;
      end
      else
        nextOwner = firstRequester((mOwner + 1) % NumPorts, NumPorts - 1); // Skips owner
      mValid = (held >= 0);
      if (held >= 0)
        mFlit = mBuf[held][mHead[held]];
      for (int p = 0; p < NumPorts; p++)
      begin
        if (mSize[p] > 0 && mBuf[p][mHead[p]].flitId == Header)
          mLimit[p] = int'(mBuf[p][mHead[p]].length);
        mCount[p] = (p == held) ? mCount[p] + 1 : 0;
        wasFull   = (mSize[p] == QueueDepth);
        if (p == held)
        begin
          mHead[p] = (mHead[p] + 1) % QueueDepth;
          mSize[p] = mSize[p] - 1;
        end
        if (inPush[p] && !wasFull)
        begin
          mBuf[p][(mHead[p] + mSize[p]) % QueueDepth] = inFlit[p];
          mSize[p] = mSize[p] + 1;
        end
      end
      mOwner = nextOwner;
    end
  end

  task automatic stopWithFailure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkOutputs();
    assert (outValid === mValid)
    else
      stopWithFailure($sformatf("MISMATCH outValid: got %h expected %h", outValid, mValid));
    if (mValid)
    begin
      assert (outFlit === mFlit)
      else
        stopWithFailure($sformatf("MISMATCH outFlit: got %h expected %h", outFlit, mFlit));
      outCount++;
    end
    for (int p = 0; p < NumPorts; p++)
    begin
      assert (full[p] === (mSize[p] == QueueDepth))
      else
        stopWithFailure($sformatf("MISMATCH full[%0d]: got %h expected %h", p, full[p],
                                  mSize[p] == QueueDepth));
    end
  endtask

  // Payload holds source port, sequence number and a random byte
  function automatic flitT buildFlit(input int port, input int idx, input int burst,
                                     input logic [11:0] len);
    flitT f;
    f = '0;
    if (idx == 0)
    begin
      f.flitId = Header;
      f.length = len;
    end
    else if (idx == burst - 1)
      f.flitId = Tail;
    else
      f.flitId = Body;
    f.payload = {3'(port), 5'(seqNum[port]), 8'($urandom)};
    return f;
  endfunction

  task automatic drivePushes(input entryT e, input int c);
    for (int p = 0; p < NumPorts; p++)
    begin
      if (c < int'(e.burst[p]))
      begin
        inFlit[p] = buildFlit(p, c, int'(e.burst[p]), e.hdrLen[p]);
        inPush[p] = 1'b1;
        seqNum[p]++;
      end
      else
        inPush[p] = 1'b0;
    end
  endtask

  initial
  begin : stimulus
    int unsigned seedDummy;
    entryT       e;
    int          maxBurst;
    seedDummy = $urandom(32'h7c9f_26b6);
    rst       = 1'b1;
    inPush    = '0;
    outCount  = 0;
    for (int p = 0; p < NumPorts; p++)
    begin
      inFlit[p] = '0;
      seqNum[p] = 0;
    end
    repeat (3)
    begin
      @(negedge clk);
      checkOutputs();
    end
    rst = 1'b0;
    for (int i = 0; i < NumEntries; i++)
    begin
      e        = stimTab[i];
      outCount = 0;
      maxBurst = 0;
      for (int p = 0; p < NumPorts; p++)
        if (int'(e.burst[p]) > maxBurst)
          maxBurst = int'(e.burst[p]);
      for (int c = 0; c < maxBurst; c++)
      begin
        @(negedge clk);
        checkOutputs();
        drivePushes(e, c);
      end
      @(negedge clk);
      checkOutputs();
      inPush = '0;
      while (outCount < int'(e.expected))
      begin
        @(negedge clk);
        checkOutputs();
      end
      // Nothing may leave during the gap
      repeat (int'(e.gap))
      begin
        @(negedge clk);
        checkOutputs();
        assert (outValid === 1'b0)
        else
          stopWithFailure($sformatf("MISMATCH outValid: got %h expected %h in idle gap",
                                    outValid, 1'b0));
      end
      assert (outCount == int'(e.expected))
      else
        stopWithFailure($sformatf("MISMATCH outCount: got %h expected %h for entry %0d",
                                  outCount, e.expected, i));
    end
    $display("Result: PASSED");
    $finish;
  end

  initial
  begin : watchdog
    int budget;
    budget = 20;
    for (int i = 0; i < NumEntries; i++)
      budget += int'(stimTab[i].gap) + 2 * NumPorts + 8 * int'(stimTab[i].expected);
    #(budget * ClkPeriod);
    stopWithFailure("Timeout: the output port stopped delivering flits before the end");
  end

endmodule

//--- routerOutputPort.f
src/nocPkg.sv
src/grantTimer.sv
src/portArbiter.sv
src/inputQueue.sv
src/outputStage.sv
src/routerOutputPort.sv
sim/routerOutputPort_props.sv
sim/routerOutputPort_tb.sv

//--- Bender.yml
package:
  name: routerOutputPort

sources:
  - files:
      - src/nocPkg.sv
      - src/grantTimer.sv
      - src/portArbiter.sv
      - src/inputQueue.sv
      - src/outputStage.sv
      - src/routerOutputPort.sv
  - target: simulation
    files:
      - sim/routerOutputPort_props.sv
      - sim/routerOutputPort_tb.sv
